// ==== include/invert_defines.svh ====
/*
  Invert block address map
  Settings bus write addresses, readback addresses and the word
  returned for an unmapped readback address
*/
`ifndef INVERT_DEFINES_SVH
`define INVERT_DEFINES_SVH

//////////////////////////////
// Settings bus addresses
//////////////////////////////

// 32-bit scratch register
`define SR_TEST_REG   8'd128
// Stream IDs for output 0, src in [31:16], dst in [15:0]
`define SR_SID0       8'd129
// Stream IDs for output 1, same layout
`define SR_SID1       8'd130
// Bit 0 clears output 0 seqnum, bit 1 clears output 1
`define SR_CLEAR_SEQ  8'd131

//////////////////////////////
// Readback addresses
//////////////////////////////

`define RB_TEST       8'd0
`define RB_SID0       8'd1
`define RB_SID1       8'd2

// Unmapped readback address
`define RB_BAD_ADDR   64'h0BAD_C0DE_0BAD_C0DE

`endif

// ==== src/invert_pkg.sv ====
/*
  Invert block types
  Packet header, stream beat and stream ID pair, plus the enums for
  packet type and the header stamper FSM
*/
package invert_pkg;

  // Packet type field of the header
  typedef enum logic [1:0] {
    PKT_DATA     = 2'b00,
    PKT_DATA_EOB = 2'b01,
    PKT_CMD      = 2'b10,
    PKT_RESP     = 2'b11
  } pkt_type_e;

  // Simplified packet header, same on every beat of a packet
  typedef struct packed {
    pkt_type_e   pkt_type;
    logic        has_time;
    logic [11:0] seqnum;
    logic [15:0] length;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } cvita_hdr_t;

  // One stream beat with its header as sideband
  typedef struct packed {
    logic [31:0] tdata;
    logic        tlast;
    cvita_hdr_t  tuser;
  } axis_beat_t;

  // Source ID sits in the upper half of the setting word
  typedef struct packed {
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } sid_pair_t;

  // Header stamper FSM
  typedef enum logic {
    STAMP_IDLE   = 1'b0,
    STAMP_IN_PKT = 1'b1
  } stamp_state_e;

endpackage

// ==== src/setting_regs.sv ====
/*
  Settings register bank
  Decodes settings bus writes into the test and stream ID registers,
  turns sequence clear writes into one-cycle pulses and serves readback
*/
`timescale 1ns/1ps
`include "invert_defines.svh"

module setting_regs
  import invert_pkg::*;
(
  input  logic        ce_clk,
  input  logic        i_arst_n,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [7:0]  i_rb_addr,
  output logic [63:0] o_rb_data,
  output sid_pair_t   o_sid0,
  output sid_pair_t   o_sid1,
  output logic [1:0]  o_clear_seq
);

  logic [31:0] test_reg;
  sid_pair_t   sid0_reg;
  sid_pair_t   sid1_reg;
  logic [1:0]  clear_seq;

  logic wr_test;
  logic wr_sid0;
  logic wr_sid1;
  logic wr_clear;

  // Strobe qualifies address and data
  assign wr_test  = i_set_stb && (i_set_addr == `SR_TEST_REG);
  assign wr_sid0  = i_set_stb && (i_set_addr == `SR_SID0);
  assign wr_sid1  = i_set_stb && (i_set_addr == `SR_SID1);
  assign wr_clear = i_set_stb && (i_set_addr == `SR_CLEAR_SEQ);

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      test_reg  <= '0;
      sid0_reg  <= '0;
      sid1_reg  <= '0;
      clear_seq <= '0;
    end else begin
      if (wr_test) begin
        test_reg <= i_set_data;
      end
      if (wr_sid0) begin
        sid0_reg <= i_set_data;
      end
      if (wr_sid1) begin
        sid1_reg <= i_set_data;
      end
      // One-cycle clear pulse for each write
      clear_seq <= wr_clear ? i_set_data[1:0] : 2'b00;
    end
  end

  assign o_sid0      = sid0_reg;
  assign o_sid1      = sid1_reg;
  assign o_clear_seq = clear_seq;

  //////////////////////////////
  // Readback mux
  //////////////////////////////
  always_comb begin
    case (i_rb_addr)
      `RB_TEST: o_rb_data = {32'd0, test_reg};
      `RB_SID0: o_rb_data = {32'd0, sid0_reg};
      `RB_SID1: o_rb_data = {32'd0, sid1_reg};
      default:  o_rb_data = `RB_BAD_ADDR;
    endcase
  end

endmodule

// ==== src/pass_thru_and_invert.sv ====
/*
  Stream fork with inversion
  Copies each input beat into two registered output slots, one
  unchanged and one with the data bits inverted
*/
`timescale 1ns/1ps

module pass_thru_and_invert
  import invert_pkg::*;
(
  input  logic       ce_clk,
  input  logic       i_arst_n,
  // Input stream
  input  logic       i_tvalid,
  input  axis_beat_t i_tbeat,
  output logic       o_tready,
  // Pass-through copy
  output logic       o_pass_tvalid,
  output axis_beat_t o_pass_tbeat,
  input  logic       i_pass_tready,
  // Inverted copy
  output logic       o_inv_tvalid,
  output axis_beat_t o_inv_tbeat,
  input  logic       i_inv_tready
);

  localparam int NUM_OUT = 2;
  localparam int PASS    = 0;
  localparam int INV     = 1;

  logic [NUM_OUT-1:0] slot_vld;
  logic [NUM_OUT-1:0] slot_rdy;
  logic [NUM_OUT-1:0] slot_free;
  axis_beat_t         slot_beat [NUM_OUT];
  axis_beat_t         fork_beat [NUM_OUT];
  logic               in_xfer;

  //////////////////////////////
  // Fork data
  //////////////////////////////

  // Header and tlast go to both copies as they are
  always_comb begin
    fork_beat[PASS]      = i_tbeat;
    fork_beat[INV]       = i_tbeat;
    fork_beat[INV].tdata = ~i_tbeat.tdata;
  end

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign slot_rdy[PASS] = i_pass_tready;
  assign slot_rdy[INV]  = i_inv_tready;

  // Slot can take a beat when empty or emptying this cycle
  assign slot_free = ~slot_vld | slot_rdy;

  // Input waits for both slots so neither copy is dropped
  assign o_tready = &slot_free;
  assign in_xfer  = i_tvalid & o_tready;

  // Each slot drains on its own; an emptied slot waits for the other
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      slot_vld <= '0;
    end else begin
      for (int i = 0; i < NUM_OUT; i++) begin
        if (in_xfer) begin
          slot_vld[i] <= 1'b1;
        end else if (slot_rdy[i]) begin
          slot_vld[i] <= 1'b0;
        end
      end
    end
  end

  // Slot payload
  always_ff @(posedge ce_clk) begin
    if (in_xfer) begin
      for (int i = 0; i < NUM_OUT; i++) begin
        slot_beat[i] <= fork_beat[i];
      end
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign o_pass_tvalid = slot_vld[PASS];
  assign o_pass_tbeat  = slot_beat[PASS];
  assign o_inv_tvalid  = slot_vld[INV];
  assign o_inv_tbeat   = slot_beat[INV];

endmodule

// ==== src/hdr_stamp.sv ====
/*
  Header stamper
  Overwrites the stream IDs of each packet and numbers packets
  with a 12-bit sequence counter, with no added latency
*/
`timescale 1ns/1ps

module hdr_stamp
  import invert_pkg::*;
(
  input  logic       ce_clk,
  input  logic       i_arst_n,
  input  sid_pair_t  i_sid,
  input  logic       i_clear_seq,
  input  logic       i_tvalid,
  input  axis_beat_t i_tbeat,
  output logic       o_tready,
  output logic       o_tvalid,
  output axis_beat_t o_tbeat,
  input  logic       i_tready
);

  stamp_state_e state;
  logic [11:0]  seq_cnt;
  logic [11:0]  seq_lat;
  logic [11:0]  seq_cur;
  sid_pair_t    sid_lat;
  sid_pair_t    sid_cur;
  logic         clr_pend;
  logic         pkt_open;
  logic         last_xfer;

  assign o_tready  = i_tready;
  assign o_tvalid  = i_tvalid;
  assign last_xfer = i_tvalid & i_tready & i_tbeat.tlast;
  assign pkt_open  = (state == STAMP_IN_PKT) | i_tvalid;

  // First beat shows live values, the rest of the packet the held ones
  assign seq_cur = (state == STAMP_IDLE) ? seq_cnt : seq_lat;
  assign sid_cur = (state == STAMP_IDLE) ? i_sid : sid_lat;

  always_comb begin
    o_tbeat               = i_tbeat;
    o_tbeat.tuser.seqnum  = seq_cur;
    o_tbeat.tuser.src_sid = sid_cur.src_sid;
    o_tbeat.tuser.dst_sid = sid_cur.dst_sid;
  end

  // FSM, a packet opens as soon as its first beat is presented
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= STAMP_IDLE;
    end else begin
      case (state)
        STAMP_IDLE:   if (i_tvalid && !last_xfer) state <= STAMP_IN_PKT;
        STAMP_IN_PKT: if (last_xfer) state <= STAMP_IDLE;
        default:      state <= STAMP_IDLE;
      endcase
    end
  end

  always_ff @(posedge ce_clk) begin
    if (state == STAMP_IDLE && i_tvalid) begin
      seq_lat <= seq_cnt;
      sid_lat <= i_sid;
    end
  end

  // Clear during an open packet is remembered until its last beat
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      seq_cnt  <= '0;
      clr_pend <= 1'b0;
    end else if (last_xfer) begin
      seq_cnt  <= (i_clear_seq || clr_pend) ? 12'd0 : seq_cur + 12'd1;
      clr_pend <= 1'b0;
    end else if (i_clear_seq) begin
      seq_cnt  <= '0;
      clr_pend <= pkt_open;
    end
  end

endmodule

// ==== src/noc_block_invert.sv ====
/*
  Invert NoC block
  One input stream forked into a pass-through and an inverted output,
  each with its own stream IDs and packet sequence numbers
*/
`timescale 1ns/1ps

module noc_block_invert
  import invert_pkg::*;
(
  input  logic        ce_clk,
  input  logic        i_arst_n,
  // Settings bus and readback
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [7:0]  i_rb_addr,
  output logic [63:0] o_rb_data,
  // Input stream
  input  logic        i_tvalid,
  input  axis_beat_t  i_tbeat,
  output logic        o_tready,
  // Output 0, pass-through
  output logic        o_pass_tvalid,
  output axis_beat_t  o_pass_tbeat,
  input  logic        i_pass_tready,
  // Output 1, inverted
  output logic        o_inv_tvalid,
  output axis_beat_t  o_inv_tbeat,
  input  logic        i_inv_tready
);

  sid_pair_t  sid0;
  sid_pair_t  sid1;
  logic [1:0] clear_seq;

  logic       pass_tvalid;
  axis_beat_t pass_tbeat;
  logic       pass_tready;
  logic       inv_tvalid;
  axis_beat_t inv_tbeat;
  logic       inv_tready;

  //////////////////////////////
  // Settings
  //////////////////////////////
  setting_regs u_setting_regs (
    .ce_clk      (ce_clk),
    .i_arst_n    (i_arst_n),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .i_rb_addr   (i_rb_addr),
    .o_rb_data   (o_rb_data),
    .o_sid0      (sid0),
    .o_sid1      (sid1),
    .o_clear_seq (clear_seq)
  );

  //////////////////////////////
  // Fork and invert
  //////////////////////////////
  pass_thru_and_invert u_pass_thru_and_invert (
    .ce_clk        (ce_clk),
    .i_arst_n      (i_arst_n),
    .i_tvalid      (i_tvalid),
    .i_tbeat       (i_tbeat),
    .o_tready      (o_tready),
    .o_pass_tvalid (pass_tvalid),
    .o_pass_tbeat  (pass_tbeat),
    .i_pass_tready (pass_tready),
    .o_inv_tvalid  (inv_tvalid),
    .o_inv_tbeat   (inv_tbeat),
    .i_inv_tready  (inv_tready)
  );

  //////////////////////////////
  // Header stampers
  //////////////////////////////
  hdr_stamp stamp_pass (
    .ce_clk      (ce_clk),
    .i_arst_n    (i_arst_n),
    .i_sid       (sid0),
    .i_clear_seq (clear_seq[0]),
    .i_tvalid    (pass_tvalid),
    .i_tbeat     (pass_tbeat),
    .o_tready    (pass_tready),
    .o_tvalid    (o_pass_tvalid),
    .o_tbeat     (o_pass_tbeat),
    .i_tready    (i_pass_tready)
  );

  hdr_stamp stamp_inv (
    .ce_clk      (ce_clk),
    .i_arst_n    (i_arst_n),
    .i_sid       (sid1),
    .i_clear_seq (clear_seq[1]),
    .i_tvalid    (inv_tvalid),
    .i_tbeat     (inv_tbeat),
    .o_tready    (inv_tready),
    .o_tvalid    (o_inv_tvalid),
    .o_tbeat     (o_inv_tbeat),
    .i_tready    (i_inv_tready)
  );

endmodule

// ==== verification/noc_block_invert_checker.sv ====
/*
  Invert block checker
  Bound assertions on the output handshakes, reset and clear pulses
*/
`timescale 1ns/1ps

module noc_block_invert_checker
  import invert_pkg::*;
(
  input logic       ce_clk,
  input logic       i_arst_n,
  input logic       i_pass_tvalid,
  input axis_beat_t i_pass_tbeat,
  input logic       i_pass_tready,
  input logic       i_inv_tvalid,
  input axis_beat_t i_inv_tbeat,
  input logic       i_inv_tready,
  input logic [1:0] i_clear_seq
);

  // Failure counts per property
  int unsigned pass_hold_fails = 0;
  int unsigned inv_hold_fails  = 0;
  int unsigned reset_fails     = 0;
  int unsigned clear_fails     = 0;

  //////////////////////////////
  // Stalled beats hold
  //////////////////////////////
  a_pass_hold: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    i_pass_tvalid && !i_pass_tready |=> i_pass_tvalid && $stable(i_pass_tbeat))
    else begin
      pass_hold_fails++;
      $error("Output 0 dropped or changed a stalled beat");
    end

  a_inv_hold: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    i_inv_tvalid && !i_inv_tready |=> i_inv_tvalid && $stable(i_inv_tbeat))
    else begin
      inv_hold_fails++;
      $error("Output 1 dropped or changed a stalled beat");
    end

  // No output traffic while in reset
  a_reset_quiet: assert property (@(posedge ce_clk)
    !i_arst_n |-> !i_pass_tvalid && !i_inv_tvalid)
    else begin
      reset_fails++;
      $error("Output valid high during reset");
    end

  // Clear pulses are single cycle per output
  a_clear_pulse: assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    |i_clear_seq |=> (i_clear_seq & $past(i_clear_seq)) == 2'b00)
    else begin
      clear_fails++;
      $error("Sequence clear held high for two cycles");
    end

endmodule

// ==== verification/tb_noc_block_invert.sv ====
/*
  Testbench for the invert NoC block
  LFSR driven packets, back-pressure and settings writes, checked
  against a reference model with one expected queue per output
*/
`timescale 1ns/1ps
`include "invert_defines.svh"

module tb_noc_block_invert
  import invert_pkg::*;
();

  localparam logic [31:0] LFSR_SEED = 32'h8109_da1b;
  localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;
  localparam int NUM_SEGMENTS = 12;
  localparam int MAX_PKTS     = 6;
  localparam int MAX_LEN      = 16;
  localparam int WRAP_PKTS    = 4100;
  localparam int MAX_BEATS    = NUM_SEGMENTS * MAX_PKTS * MAX_LEN + WRAP_PKTS;
  localparam int TIMEOUT_NS   = MAX_BEATS * 4 * 20 + 20000;

  logic        ce_clk;
  logic        i_arst_n;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic [7:0]  i_rb_addr;
  logic [63:0] o_rb_data;
  logic        i_tvalid;
  axis_beat_t  i_tbeat;
  logic        o_tready;
  logic        o_pass_tvalid;
  axis_beat_t  o_pass_tbeat;
  logic        i_pass_tready;
  logic        o_inv_tvalid;
  axis_beat_t  o_inv_tbeat;
  logic        i_inv_tready;

  // Reference model state
  logic [31:0] lfsr;
  axis_beat_t  exp_pass [$];
  axis_beat_t  exp_inv [$];
  sid_pair_t   m_sid0;
  sid_pair_t   m_sid1;
  logic [31:0] m_test;
  logic [11:0] m_seq0;
  logic [11:0] m_seq1;
  int          checks = 0;
  int          errors = 0;
  int          pass_beats = 0;
  int          inv_beats = 0;
  int          sva_fails;

  noc_block_invert DUT (.*);

  bind noc_block_invert noc_block_invert_checker u_checker (
    .ce_clk        (ce_clk),
    .i_arst_n      (i_arst_n),
    .i_pass_tvalid (o_pass_tvalid),
    .i_pass_tbeat  (o_pass_tbeat),
    .i_pass_tready (i_pass_tready),
    .i_inv_tvalid  (o_inv_tvalid),
    .i_inv_tbeat   (o_inv_tbeat),
    .i_inv_tready  (i_inv_tready),
    .i_clear_seq   (clear_seq)
  );

  initial begin
    ce_clk = 1'b0;
    forever #2 ce_clk = ~ce_clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [7:0] pick_bad_addr();
    logic [7:0] a;
    a = 8'(rand_bits(8));
    if (a < 8'd3) begin
      a = a + 8'd3;
    end
    return a;
  endfunction

  // Both copies of an accepted beat, as each output should show it
  function automatic void accept_beat(input axis_beat_t beat);
    axis_beat_t b0;
    axis_beat_t b1;
    b0                  = beat;
    b0.tuser.seqnum     = m_seq0;
    b0.tuser.src_sid    = m_sid0.src_sid;
    b0.tuser.dst_sid    = m_sid0.dst_sid;
    b1                  = beat;
    b1.tdata            = ~beat.tdata;
    b1.tuser.seqnum     = m_seq1;
    b1.tuser.src_sid    = m_sid1.src_sid;
    b1.tuser.dst_sid    = m_sid1.dst_sid;
    exp_pass.push_back(b0);
    exp_inv.push_back(b1);
    if (beat.tlast) begin
      m_seq0 = m_seq0 + 12'd1;
      m_seq1 = m_seq1 + 12'd1;
    end
  endfunction

  // Step to 1 ns after the next edge and pick new output readys
  task automatic next_cycle();
    @(posedge ce_clk);
    #1;
    i_pass_tready = (rand_bits(2) != 0);
    i_inv_tready  = (rand_bits(2) != 0);
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    next_cycle();
    i_set_stb  = 1'b0;
  endtask

  task automatic check_readback(input logic [7:0] addr, input logic [63:0] exp);
    i_rb_addr = addr;
    @(negedge ce_clk);
    checks++;
    assert (o_rb_data === exp) else begin
      errors++;
      $display("ERR %0t: readback at %0d gave %h, expected %h", $time, addr, o_rb_data, exp);
    end
    next_cycle();
  endtask

  task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s beat data %h last %b hdr %h, expected data %h last %b hdr %h",
               $time, name, got.tdata, got.tlast, got.tuser, exp.tdata, exp.tlast, exp.tuser);
    end
  endtask

  // Settings only change while no packet is under way
  task automatic update_settings();
    logic [31:0] v;
    logic [1:0]  clr;
    if (rand_bits(1) != 0) begin
      v = rand_bits(32);
      write_setting(`SR_SID0, v);
      m_sid0 = v;
    end
    if (rand_bits(1) != 0) begin
      v = rand_bits(32);
      write_setting(`SR_SID1, v);
      m_sid1 = v;
    end
    if (rand_bits(1) != 0) begin
      v = rand_bits(32);
      write_setting(`SR_TEST_REG, v);
      m_test = v;
    end
    if (rand_bits(1) != 0) begin
      clr = 2'(rand_bits(2));
      write_setting(`SR_CLEAR_SEQ, {30'(rand_bits(30)), clr});
      if (clr[0]) begin
        m_seq0 = '0;
      end
      if (clr[1]) begin
        m_seq1 = '0;
      end
    end
    next_cycle();
    next_cycle();
    check_readback(`RB_TEST, {32'd0, m_test});
    check_readback(`RB_SID0, {32'd0, m_sid0});
    check_readback(`RB_SID1, {32'd0, m_sid1});
    check_readback(pick_bad_addr(), `RB_BAD_ADDR);
  endtask

  task automatic send_packet(input int len);
    cvita_hdr_t hdr;
    axis_beat_t beat;
    logic       acc;
    hdr.pkt_type = pkt_type_e'(2'(rand_bits(2)));
    hdr.has_time = 1'(rand_bits(1));
    hdr.seqnum   = 12'(rand_bits(12));
    hdr.length   = 16'(rand_bits(16));
    hdr.src_sid  = 16'(rand_bits(16));
    hdr.dst_sid  = 16'(rand_bits(16));
    for (int i = 0; i < len; i++) begin
      // Random idle gap before each beat
      while (rand_bits(2) == 0) begin
        i_tvalid = 1'b0;
        next_cycle();
      end
      beat.tdata = rand_bits(32);
      beat.tlast = (i == len - 1);
      beat.tuser = hdr;
      i_tvalid   = 1'b1;
      i_tbeat    = beat;
      acc        = 1'b0;
      while (!acc) begin
        @(negedge ce_clk);
        acc = o_tready;
        if (acc) begin
          accept_beat(beat);
        end
        next_cycle();
      end
    end
    i_tvalid = 1'b0;
  endtask

  task automatic drain();
    i_tvalid = 1'b0;
    while (exp_pass.size() != 0 || exp_inv.size() != 0) begin
      next_cycle();
    end
    next_cycle();
  endtask

  //////////////////////////////
  // Output scoreboards
  //////////////////////////////
  always @(negedge ce_clk) begin
    if (i_arst_n && o_pass_tvalid && i_pass_tready) begin
      pass_beats++;
      checks++;
      assert (exp_pass.size() != 0) else begin
        errors++;
        $display("Output 0 delivered a beat at %0t that was never accepted", $time);
      end
      if (exp_pass.size() != 0) begin
        check_beat("pass", o_pass_tbeat, exp_pass.pop_front());
      end
    end
    if (i_arst_n && o_inv_tvalid && i_inv_tready) begin
      inv_beats++;
      checks++;
      assert (exp_inv.size() != 0) else begin
        errors++;
        $display("Output 1 delivered a beat at %0t that was never accepted", $time);
      end
      if (exp_inv.size() != 0) begin
        check_beat("inv", o_inv_tbeat, exp_inv.pop_front());
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the outputs stopped delivering beats", TIMEOUT_NS);
    $display("Test FAILED");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    int npkts;
    lfsr          = LFSR_SEED;
    m_sid0        = '0;
    m_sid1        = '0;
    m_test        = '0;
    m_seq0        = '0;
    m_seq1        = '0;
    i_arst_n      = 1'b0;
    i_set_stb     = 1'b0;
    i_set_addr    = '0;
    i_set_data    = '0;
    i_rb_addr     = '0;
    i_tvalid      = 1'b0;
    i_tbeat       = '0;
    i_pass_tready = 1'b0;
    i_inv_tready  = 1'b0;
    repeat (10) @(posedge ce_clk);
    #1;
    i_arst_n = 1'b1;
    @(negedge ce_clk);
    checks++;
    assert (!o_pass_tvalid && !o_inv_tvalid && o_tready) else begin
      errors++;
      $display("After reset the output valids are not low or the input is not ready");
    end
    next_cycle();
    check_readback(`RB_TEST, 64'd0);
    check_readback(`RB_SID0, 64'd0);
    check_readback(`RB_SID1, 64'd0);
    check_readback(pick_bad_addr(), `RB_BAD_ADDR);
    for (int s = 0; s < NUM_SEGMENTS; s++) begin
      update_settings();
      npkts = 1 + int'(rand_bits(3) % MAX_PKTS);
      for (int p = 0; p < npkts; p++) begin
        send_packet(1 + int'(rand_bits(4)));
      end
      drain();
    end
    // Enough single-beat packets to wrap both sequence counters
    for (int p = 0; p < WRAP_PKTS; p++) begin
      send_packet(1);
    end
    drain();
    checks++;
    assert (exp_pass.size() == 0 && exp_inv.size() == 0) else begin
      errors++;
      $display("Beats never delivered: %0d on output 0, %0d on output 1",
               exp_pass.size(), exp_inv.size());
    end
    sva_fails = DUT.u_checker.pass_hold_fails + DUT.u_checker.inv_hold_fails
              + DUT.u_checker.reset_fails + DUT.u_checker.clear_fails;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures, %0d/%0d beats out",
             checks, errors, sva_fails, pass_beats, inv_beats);
    if (errors == 0 && sva_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
src/invert_pkg.sv
src/setting_regs.sv
src/pass_thru_and_invert.sv
src/hdr_stamp.sv
src/noc_block_invert.sv
verification/noc_block_invert_checker.sv
verification/tb_noc_block_invert.sv
